// ==== Bender.yml ====
package:
  name: dap_dp

export_include_dirs:
  - src

sources:
  - src/dp_pkg.sv
  - src/dp_ctrl_stat.sv
  - src/dp_ap_link.sv
  - src/dp_pwr_ctrl.sv
  - src/ap_regs.sv
  - src/dap_dp_top.sv
  - target: test
    files:
      - dv/dp_checker.sv
      - dv/tb_dap_dp.sv

// ==== dv/dp_checker.sv ====
// Testbench checker watching the debug port pins, comparing host results and keeping counts
`timescale 1ns/100ps
`include "dp_consts.svh"

module dp_checker (
  input  logic        swclktck,
  input  logic        dpreset_n,
  input  logic        host_req_i,
  input  logic [1:0]  host_op_i,
  input  logic [3:0]  host_addr_i,
  input  logic [31:0] host_wdata_i,
  input  logic        host_done_o,
  input  logic [31:0] host_rdata_o,
  input  logic        host_err_o,
  input  logic        cdbgpwrupreq_o,
  input  logic        cdbgpwrupack_i
);
  import dp_pkg::*;

  // Software power request bit in CTRL/STAT
  localparam int pwrupreq_bit = 28;

  int          pass_cnt = 0;
  int          fail_cnt = 0;
  logic [31:0] got_rdata;
  logic        got_err;
  logic        dp_acc_q;
  logic        sw_req_q;
  logic        pin_req_q;
  logic        pin_ack_q;

  // ----------------------------------------
  // Host done capture
  // ----------------------------------------
  // Outputs sampled on the falling edge away from the drive edge
  task automatic wait_done(input int limit, output bit seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && (n < limit))
    begin
      @(negedge swclktck);
      n++;
      if (host_done_o)
      begin
        seen      = 1'b1;
        got_rdata = host_rdata_o;
        got_err   = host_err_o;
      end
    end
  endtask

  // Compare one host access and stay silent on a miss while polling
  task automatic judge_access(input string name, input logic [31:0] exp_rd,
                              input logic exp_err, input bit chk_rd, input bit seen,
                              input bit final_try, output bit matched);
    matched = seen && (got_err === exp_err) && (!chk_rd || (got_rdata === exp_rd));
    if (!seen)
    begin
      $display("%s: host access never finished, no done pulse within the timeout", name);
      fail_cnt++;
    end
    else if (matched)
    begin
      $display("pass %s", name);
      pass_cnt++;
    end
    else if (final_try)
    begin
      if (got_err !== exp_err)
        $display("mismatch %s err expected %0b actual %0b", name, exp_err, got_err);
      else
        $display("mismatch %s rdata expected %08h actual %08h", name, exp_rd, got_rdata);
      fail_cnt++;
    end
  endtask

  // Wait for the power request pin to reach a level
  task automatic wait_pin_level(input string name, input logic level, input int limit);
    int n;
    n = 0;
    while ((cdbgpwrupreq_o !== level) && (n < limit))
    begin
      @(negedge swclktck);
      n++;
    end
    if (cdbgpwrupreq_o === level)
    begin
      $display("pass %s", name);
      pass_cnt++;
    end
    else
    begin
      $display("%s: power request pin did not reach %0b in time", name, level);
      fail_cnt++;
    end
  endtask

  // Single level check
  task automatic check_level(input string name, input logic exp, input logic act);
    if (act === exp)
    begin
      $display("pass %s", name);
      pass_cnt++;
    end
    else
    begin
      $display("mismatch %s expected %0b actual %0b", name, exp, act);
      fail_cnt++;
    end
  endtask

  task automatic print_totals();
    $display("tests %0d passed %0d failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
  endtask

  // ----------------------------------------
  // Cycle monitors
  // ----------------------------------------
  // Falling edge samples with one cycle of history
  always @(negedge swclktck)
  begin
    if (!dpreset_n)
      sw_req_q = 1'b0;
    else
    begin
      // DP register accesses answer on the next cycle
      if (dp_acc_q && (host_done_o !== 1'b1))
      begin
        $display("DP register access got no done pulse one cycle after its request");
        fail_cnt++;
      end
      // Four phase protocol lets the request move only once the ack has matched it
      if ((cdbgpwrupreq_o !== pin_req_q) && (pin_req_q !== pin_ack_q))
      begin
        $display("power request pin changed before the acknowledge pin had followed it");
        fail_cnt++;
      end
      // The pin only ever heads for the software request
      if ((cdbgpwrupreq_o !== pin_req_q) && (cdbgpwrupreq_o !== sw_req_q))
      begin
        $display("power request pin moved away from the software request");
        fail_cnt++;
      end
      if (host_req_i && (host_op_i == OP_DP_WR) && (host_addr_i == `DP_ADDR_CTRL_STAT))
        sw_req_q = host_wdata_i[pwrupreq_bit];
    end
    dp_acc_q  = dpreset_n && host_req_i &&
                ((host_op_i == OP_DP_RD) || (host_op_i == OP_DP_WR));
    pin_req_q = cdbgpwrupreq_o;
    pin_ack_q = cdbgpwrupack_i;
  end

endmodule

// ==== dv/tb_dap_dp.sv ====
// Debug port testbench with clock, reset, power pin model and a table of host accesses
`timescale 1ns/100ps
`include "dp_consts.svh"

module tb_dap_dp;
  import dp_pkg::*;

  localparam int k_acc        = 0;
  localparam int k_poll       = 1;
  localparam int k_pin        = 2;
  localparam int done_timeout = 40;
  localparam int pin_timeout  = 60;
  localparam int poll_tries   = 20;

  logic             swclktck;
  logic             dpreset_n;
  logic             host_req_i;
  host_op_e         host_op_i;
  logic [3:0]       host_addr_i;
  ctrl_stat_u       host_wdata_i;
  logic             host_done_o;
  logic [31:0]      host_rdata_o;
  logic             host_err_o;
  logic             cdbgpwrupreq_o;
  logic             cdbgpwrupack_i;
  logic [31:0]      lcg_state = 32'h0d23_d6ec;

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------
  string            name_tab [64];
  int               kind_tab [64];
  host_op_e         op_tab [64];
  logic [3:0]       addr_tab [64];
  logic [31:0]      wdata_tab [64];
  logic [31:0]      exp_rd_tab [64];
  logic             exp_err_tab [64];
  bit               chk_rd_tab [64];
  int               n_rows = 0;

  dap_dp_top dut_i (
    .swclktck       (swclktck),
    .dpreset_n      (dpreset_n),
    .host_req_i     (host_req_i),
    .host_op_i      (host_op_i),
    .host_addr_i    (host_addr_i),
    .host_wdata_i   (host_wdata_i),
    .host_done_o    (host_done_o),
    .host_rdata_o   (host_rdata_o),
    .host_err_o     (host_err_o),
    .cdbgpwrupreq_o (cdbgpwrupreq_o),
    .cdbgpwrupack_i (cdbgpwrupack_i)
  );

  dp_checker chk_i (
    .swclktck       (swclktck),
    .dpreset_n      (dpreset_n),
    .host_req_i     (host_req_i),
    .host_op_i      (host_op_i),
    .host_addr_i    (host_addr_i),
    .host_wdata_i   (host_wdata_i),
    .host_done_o    (host_done_o),
    .host_rdata_o   (host_rdata_o),
    .host_err_o     (host_err_o),
    .cdbgpwrupreq_o (cdbgpwrupreq_o),
    .cdbgpwrupack_i (cdbgpwrupack_i)
  );

  // 40 ns clock
  initial
    swclktck = 1'b0;
  always
    #20 swclktck = ~swclktck;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // System power controller model, ack follows request after 2 to 9 cycles
  initial
  begin : pwr_model
    int delay;
    forever
    begin
      @(posedge swclktck);
      if (dpreset_n && (cdbgpwrupreq_o !== cdbgpwrupack_i))
      begin
        delay = 2 + ((lcg_next() >> 16) % 8);
        repeat (delay - 1) @(posedge swclktck);
        cdbgpwrupack_i <= cdbgpwrupreq_o;
      end
    end
  end

  task automatic add_row(input string name, input int kind, input host_op_e op,
                         input logic [3:0] addr, input logic [31:0] wdata,
                         input logic [31:0] exp_rd, input logic exp_err, input bit chk_rd);
    name_tab[n_rows]    = name;
    kind_tab[n_rows]    = kind;
    op_tab[n_rows]      = op;
    addr_tab[n_rows]    = addr;
    wdata_tab[n_rows]   = wdata;
    exp_rd_tab[n_rows]  = exp_rd;
    exp_err_tab[n_rows] = exp_err;
    chk_rd_tab[n_rows]  = chk_rd;
    n_rows++;
  endtask

  // One cycle request pulse, driven on the rising edge
  task automatic issue_access(input int i);
    @(posedge swclktck);
    host_req_i   <= 1'b1;
    host_op_i    <= op_tab[i];
    host_addr_i  <= addr_tab[i];
    host_wdata_i <= wdata_tab[i];
    @(posedge swclktck);
    host_req_i   <= 1'b0;
  endtask

  initial
  begin : main
    logic [31:0] d [4];
    logic [3:0]  cs;
    int          tries;
    int          t;
    bit          seen;
    bit          matched;

    host_req_i     = 1'b0;
    host_op_i      = OP_DP_RD;
    host_addr_i    = '0;
    host_wdata_i   = '0;
    cdbgpwrupack_i = 1'b0;
    dpreset_n      = 1'b0;
    cs             = `DP_ADDR_CTRL_STAT;
    for (int k = 0; k < 4; k++)
      d[k] = lcg_next();

    // ----------------------------------------
    // Table rows: name kind op addr wdata exp_rd exp_err chk_rd
    // ----------------------------------------
    // CTRL/STAT bits: 29 ack, 28 req, 5 stickyerr, 2 clr_stickyerr
    add_row("cs_after_reset", k_acc, OP_DP_RD, cs, 32'h0, 32'h0, 1'b0, 1'b1);
    add_row("ap_rd_unpowered", k_acc, OP_AP_RD, 4'h0, 32'h0, 32'h0, 1'b1, 1'b1);
    add_row("cs_sticky_set", k_acc, OP_DP_RD, cs, 32'h0, 32'h20, 1'b0, 1'b1);
    add_row("clr_sticky", k_acc, OP_DP_WR, cs, 32'h4, 32'h0, 1'b0, 1'b1);
    add_row("cs_sticky_clr", k_acc, OP_DP_RD, cs, 32'h0, 32'h0, 1'b0, 1'b1);
    add_row("pwrup_req", k_acc, OP_DP_WR, cs, 32'h1000_0000, 32'h0, 1'b0, 1'b1);
    add_row("pin_req_high", k_pin, OP_DP_RD, cs, 32'h0, 32'h1, 1'b0, 1'b0);
    add_row("poll_ack_set", k_poll, OP_DP_RD, cs, 32'h0, 32'h3000_0000, 1'b0, 1'b1);
    for (int k = 0; k < 4; k++)
      add_row($sformatf("ap_wr_%0d", k), k_acc, OP_AP_WR, 4'(k << 2), d[k], 32'h0, 1'b0, 1'b0);
    for (int k = 0; k < 3; k++)
      add_row($sformatf("ap_rd_%0d", k), k_acc, OP_AP_RD, 4'(k << 2), 32'h0, d[k], 1'b0, 1'b1);
    add_row("ap_rd_reserved", k_acc, OP_AP_RD, {`AP_ADDR_RESERVED, 2'b00}, 32'h0, 32'h0,
            1'b0, 1'b1);
    // Ninth transfer leaves both link lines high
    add_row("ap_rd_odd", k_acc, OP_AP_RD, 4'h0, 32'h0, d[0], 1'b0, 1'b1);
    add_row("pwrdn_req", k_acc, OP_DP_WR, cs, 32'h0, 32'h0, 1'b0, 1'b1);
    add_row("pin_req_low", k_pin, OP_DP_RD, cs, 32'h0, 32'h0, 1'b0, 1'b0);
    add_row("poll_ack_clr", k_poll, OP_DP_RD, cs, 32'h0, 32'h0, 1'b0, 1'b1);
    add_row("ap_rd_pwrdn", k_acc, OP_AP_RD, 4'h4, 32'h0, 32'h0, 1'b1, 1'b1);
    add_row("cs_sticky_again", k_acc, OP_DP_RD, cs, 32'h0, 32'h20, 1'b0, 1'b1);

    repeat (4) @(posedge swclktck);
    dpreset_n <= 1'b1;
    @(negedge swclktck);
    chk_i.check_level("reset_pwrupreq_low", 1'b0, cdbgpwrupreq_o);
    chk_i.check_level("reset_done_low", 1'b0, host_done_o);

    for (int i = 0; i < n_rows; i++)
    begin
      if (kind_tab[i] == k_pin)
        chk_i.wait_pin_level(name_tab[i], exp_rd_tab[i][0], pin_timeout);
      else
      begin
        tries   = (kind_tab[i] == k_poll) ? poll_tries : 1;
        matched = 1'b0;
        t       = 0;
        while (!matched && (t < tries))
        begin
          issue_access(i);
          chk_i.wait_done(done_timeout, seen);
          chk_i.judge_access(name_tab[i], exp_rd_tab[i], exp_err_tab[i], chk_rd_tab[i],
                             seen, (t == tries - 1), matched);
          // A lost done ends the polling at once
          if (!seen)
            t = tries;
          t++;
        end
      end
    end

    chk_i.print_totals();
    if (chk_i.fail_cnt == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+src
src/dp_pkg.sv
src/dp_ctrl_stat.sv
src/dp_ap_link.sv
src/dp_pwr_ctrl.sv
src/ap_regs.sv
src/dap_dp_top.sv
dv/dp_checker.sv
dv/tb_dap_dp.sv

// ==== src/ap_regs.sv ====
// Access port register file answering toggle requests after a fixed delay
`timescale 1ns/100ps
`include "dp_consts.svh"

module ap_regs (
  input  logic             swclktck,
  input  logic             dpreset_n,
  input  logic             dp_req_i,
  output logic             ap_ack_o,
  input  logic             link_write_i,
  input  dp_pkg::ap_addr_t link_addr_i,
  input  logic [31:0]      link_wdata_i,
  output logic [31:0]      link_rdata_o
);

  localparam int unsigned ack_last = `AP_ACK_DELAY - 1;

  logic                 ap_ack_q;
  logic [`AP_CNT_W-1:0] cnt_q;
  logic                 req_pend;
  logic                 access;
  logic [31:0]          regs_q [3];

  // ----------------------------------------
  // Toggle detect and delay
  // ----------------------------------------
  // A request is outstanding while the two lines differ
  assign req_pend = (dp_req_i != ap_ack_q);
  assign access   = req_pend && (cnt_q == ack_last[`AP_CNT_W-1:0]);

  always_ff @(posedge swclktck or negedge dpreset_n)
  begin
    if (!dpreset_n)
    begin
      ap_ack_q <= 1'b0;
      cnt_q    <= '0;
    end
    else if (access)
    begin
      // Answer by matching the request level
      ap_ack_q <= dp_req_i;
      cnt_q    <= '0;
    end
    else if (req_pend)
      cnt_q <= cnt_q + 1'b1;
  end

  // ----------------------------------------
  // Register access
  // ----------------------------------------
  // Reserved index reads zero and drops writes
  always_ff @(posedge swclktck)
  begin
    if (access)
    begin
      case (link_addr_i)
        2'd0:
        begin
          link_rdata_o <= regs_q[0];
          if (link_write_i)
            regs_q[0] <= link_wdata_i;
        end
        2'd1:
        begin
          link_rdata_o <= regs_q[1];
          if (link_write_i)
            regs_q[1] <= link_wdata_i;
        end
        2'd2:
        begin
          link_rdata_o <= regs_q[2];
          if (link_write_i)
            regs_q[2] <= link_wdata_i;
        end
        default:
          link_rdata_o <= '0;
      endcase
    end
  end

  assign ap_ack_o = ap_ack_q;

endmodule

// ==== src/dap_dp_top.sv ====
// Debug port top joining host registers, AP link, AP registers and power control
`timescale 1ns/100ps
`include "dp_consts.svh"

module dap_dp_top (
  input  logic                  swclktck,
  input  logic                  dpreset_n,
  input  logic                  host_req_i,
  input  dp_pkg::host_op_e      host_op_i,
  input  logic [`DP_ADDR_W-1:0] host_addr_i,
  input  dp_pkg::ctrl_stat_u    host_wdata_i,
  output logic                  host_done_o,
  output logic [31:0]           host_rdata_o,
  output logic                  host_err_o,
  output logic                  cdbgpwrupreq_o,
  input  logic                  cdbgpwrupack_i
);
  import dp_pkg::*;

  // Host stage to link stage
  logic        ap_start;
  logic        ap_write;
  ap_addr_t    ap_addr;
  logic [31:0] ap_wdata;
  logic        ap_done;
  logic [31:0] ap_rdata;

  // Link stage to AP registers
  logic        dp_req;
  logic        ap_ack;
  logic        link_write;
  ap_addr_t    link_addr;
  logic [31:0] link_wdata;
  logic [31:0] link_rdata;

  // Power control
  logic        sw_pwrupreq;
  logic        sw_pwrupack;
  logic        reset_handshake;

  dp_ctrl_stat u_ctrl_stat (
    .swclktck     (swclktck),
    .dpreset_n    (dpreset_n),
    .host_req_i   (host_req_i),
    .host_op_i    (host_op_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_done_o  (host_done_o),
    .host_rdata_o (host_rdata_o),
    .host_err_o   (host_err_o),
    .pwr_ack_i    (sw_pwrupack),
    .pwr_req_o    (sw_pwrupreq),
    .ap_start_o   (ap_start),
    .ap_write_o   (ap_write),
    .ap_addr_o    (ap_addr),
    .ap_wdata_o   (ap_wdata),
    .ap_done_i    (ap_done),
    .ap_rdata_i   (ap_rdata)
  );

  dp_ap_link u_ap_link (
    .swclktck          (swclktck),
    .dpreset_n         (dpreset_n),
    .ap_start_i        (ap_start),
    .ap_write_i        (ap_write),
    .ap_addr_i         (ap_addr),
    .ap_wdata_i        (ap_wdata),
    .ap_done_o         (ap_done),
    .ap_rdata_o        (ap_rdata),
    .reset_handshake_i (reset_handshake),
    .dp_req_o          (dp_req),
    .ap_ack_i          (ap_ack),
    .link_write_o      (link_write),
    .link_addr_o       (link_addr),
    .link_wdata_o      (link_wdata),
    .link_rdata_i      (link_rdata)
  );

  ap_regs u_ap_regs (
    .swclktck     (swclktck),
    .dpreset_n    (dpreset_n),
    .dp_req_i     (dp_req),
    .ap_ack_o     (ap_ack),
    .link_write_i (link_write),
    .link_addr_i  (link_addr),
    .link_wdata_i (link_wdata),
    .link_rdata_o (link_rdata)
  );

  // Power controller watches the link lines alongside the link stage
  dp_pwr_ctrl u_pwr_ctrl (
    .swclktck          (swclktck),
    .dpreset_n         (dpreset_n),
    .sw_pwrupreq_i     (sw_pwrupreq),
    .cdbgpwrupack_i    (cdbgpwrupack_i),
    .dp_req_i          (dp_req),
    .ap_ack_i          (ap_ack),
    .sw_pwrupack_o     (sw_pwrupack),
    .cdbgpwrupreq_o    (cdbgpwrupreq_o),
    .reset_handshake_o (reset_handshake)
  );

endmodule

// ==== src/dp_ap_link.sv ====
// AP link stage running the two-phase dp_req/ap_ack toggle and injecting dummy transfers
`timescale 1ns/100ps
`include "dp_consts.svh"

module dp_ap_link (
  input  logic             swclktck,
  input  logic             dpreset_n,
  input  logic             ap_start_i,
  input  logic             ap_write_i,
  input  dp_pkg::ap_addr_t ap_addr_i,
  input  logic [31:0]      ap_wdata_i,
  output logic             ap_done_o,
  output logic [31:0]      ap_rdata_o,
  input  logic             reset_handshake_i,
  output logic             dp_req_o,
  input  logic             ap_ack_i,
  output logic             link_write_o,
  output dp_pkg::ap_addr_t link_addr_o,
  output logic [31:0]      link_wdata_o,
  input  logic [31:0]      link_rdata_i
);
  import dp_pkg::*;

  logic        dp_req_q;
  logic        host_busy_q;
  logic        dummy_busy_q;
  logic        pend_q;
  logic        pend_write_q;
  ap_addr_t    pend_addr_q;
  logic [31:0] pend_wdata_q;
  logic        link_idle;
  logic        link_free;
  logic        host_go;
  logic        dummy_go;

  // ----------------------------------------
  // Handshake state
  // ----------------------------------------
  // Idle when the AP has answered the last toggle
  assign link_idle = (dp_req_q == ap_ack_i);
  assign link_free = !host_busy_q && !dummy_busy_q;

  // A waiting host transfer goes first
  assign host_go   = (ap_start_i || pend_q) && link_free;
  // Dummy read brings both lines back low
  assign dummy_go  = reset_handshake_i && link_free && !ap_start_i && !pend_q;

  // Only host transfers are reported back
  assign ap_done_o  = host_busy_q && link_idle;
  assign ap_rdata_o = link_rdata_i;

  always_ff @(posedge swclktck or negedge dpreset_n)
  begin
    if (!dpreset_n)
    begin
      dp_req_q     <= 1'b0;
      host_busy_q  <= 1'b0;
      dummy_busy_q <= 1'b0;
      pend_q       <= 1'b0;
    end
    else
    begin
      if (host_go || dummy_go)
        dp_req_q <= ~dp_req_q;
      if (host_go)
        host_busy_q <= 1'b1;
      else if (ap_done_o)
        host_busy_q <= 1'b0;
      if (dummy_go)
        dummy_busy_q <= 1'b1;
      else if (dummy_busy_q && link_idle)
        dummy_busy_q <= 1'b0;
      // Hold a host request that arrives while a dummy is in flight
      if (host_go)
        pend_q <= 1'b0;
      else if (ap_start_i)
        pend_q <= 1'b1;
    end
  end

  // ----------------------------------------
  // Transfer payload
  // ----------------------------------------
  always_ff @(posedge swclktck)
  begin
    if (ap_start_i)
    begin
      pend_write_q <= ap_write_i;
      pend_addr_q  <= ap_addr_i;
      pend_wdata_q <= ap_wdata_i;
    end
    if (host_go)
    begin
      link_write_o <= pend_q ? pend_write_q : ap_write_i;
      link_addr_o  <= pend_q ? pend_addr_q : ap_addr_i;
      link_wdata_o <= pend_q ? pend_wdata_q : ap_wdata_i;
    end
    else if (dummy_go)
    begin
      link_write_o <= 1'b0;
      link_addr_o  <= `AP_ADDR_RESERVED;
      link_wdata_o <= '0;
    end
  end

  assign dp_req_o = dp_req_q;

endmodule

// ==== src/dp_consts.svh ====
// Debug port constants for register addresses, AP handshake timing and index bits
`ifndef DP_CONSTS_SVH
`define DP_CONSTS_SVH

// Host address width, byte addressed as in the SWD DP map
`define DP_ADDR_W 4

// DP register map
`define DP_ADDR_CTRL_STAT 4'h4

// AP register index taken from host address bits [3:2]
`define AP_IDX_MSB 3
`define AP_IDX_LSB 2

// Reserved AP index, RAZ/WI, also the target of dummy transfers
`define AP_ADDR_RESERVED 2'd3

// Cycles from dp_req toggle to ap_ack toggle
`define AP_ACK_DELAY 3

// Width of the AP delay counter, must hold AP_ACK_DELAY-1
`define AP_CNT_W 2

`endif

// ==== src/dp_ctrl_stat.sv ====
// Host register stage holding CTRL/STAT and the sticky error, issuing AP transfers
`timescale 1ns/100ps
`include "dp_consts.svh"

module dp_ctrl_stat (
  input  logic                  swclktck,
  input  logic                  dpreset_n,
  input  logic                  host_req_i,
  input  dp_pkg::host_op_e      host_op_i,
  input  logic [`DP_ADDR_W-1:0] host_addr_i,
  input  dp_pkg::ctrl_stat_u    host_wdata_i,
  output logic                  host_done_o,
  output logic [31:0]           host_rdata_o,
  output logic                  host_err_o,
  input  logic                  pwr_ack_i,
  output logic                  pwr_req_o,
  output logic                  ap_start_o,
  output logic                  ap_write_o,
  output dp_pkg::ap_addr_t      ap_addr_o,
  output logic [31:0]           ap_wdata_o,
  input  logic                  ap_done_i,
  input  logic [31:0]           ap_rdata_i
);
  import dp_pkg::*;

  logic        is_ap;
  logic        is_cs;
  logic        ap_blocked;
  logic        pwrupreq_q;
  logic        stickyerr_q;
  logic        done_q;
  logic        err_q;
  logic [31:0] rdata_q;
  ctrl_stat_u  cs_view;

  // ----------------------------------------
  // Command decode
  // ----------------------------------------
  assign is_ap      = (host_op_i == OP_AP_RD) || (host_op_i == OP_AP_WR);
  assign is_cs      = (host_addr_i == `DP_ADDR_CTRL_STAT);

  // AP traffic is only legal while software requests power
  assign ap_blocked = host_req_i && is_ap && !pwrupreq_q;
  assign ap_start_o = host_req_i && is_ap && pwrupreq_q;
  assign ap_write_o = (host_op_i == OP_AP_WR);
  assign ap_addr_o  = host_addr_i[`AP_IDX_MSB:`AP_IDX_LSB];
  assign ap_wdata_o = host_wdata_i.raw;

  // CTRL/STAT read view, ack comes live from the power controller
  always_comb
  begin
    cs_view                  = '0;
    cs_view.fld.cdbgpwrupack = pwr_ack_i;
    cs_view.fld.cdbgpwrupreq = pwrupreq_q;
    cs_view.fld.stickyerr    = stickyerr_q;
  end

  // ----------------------------------------
  // Control state
  // ----------------------------------------
  always_ff @(posedge swclktck or negedge dpreset_n)
  begin
    if (!dpreset_n)
    begin
      done_q      <= 1'b0;
      err_q       <= 1'b0;
      pwrupreq_q  <= 1'b0;
      stickyerr_q <= 1'b0;
    end
    else
    begin
      // Done and error are single cycle pulses
      done_q <= 1'b0;
      err_q  <= 1'b0;
      if (host_req_i && !is_ap)
      begin
        done_q <= 1'b1;
        if ((host_op_i == OP_DP_WR) && is_cs)
        begin
          pwrupreq_q <= host_wdata_i.fld.cdbgpwrupreq;
          if (host_wdata_i.fld.clr_stickyerr)
            stickyerr_q <= 1'b0;
        end
      end
      if (ap_blocked)
      begin
        done_q      <= 1'b1;
        err_q       <= 1'b1;
        stickyerr_q <= 1'b1;
      end
      // AP transfer finished in the link stage
      if (ap_done_i)
        done_q <= 1'b1;
    end
  end

  // Read data
  always_ff @(posedge swclktck)
  begin
    if (host_req_i && !is_ap)
      rdata_q <= ((host_op_i == OP_DP_RD) && is_cs) ? cs_view.raw : '0;
    else if (ap_blocked)
      rdata_q <= '0;
    else if (ap_done_i)
      rdata_q <= ap_rdata_i;
  end

  assign host_done_o  = done_q;
  assign host_err_o   = err_q;
  assign host_rdata_o = rdata_q;
  assign pwr_req_o    = pwrupreq_q;

endmodule

// ==== src/dp_pkg.sv ====
// Debug port shared types for host commands, AP indices and the CTRL/STAT word
package dp_pkg;

  // ----------------------------------------
  // Host command encoding
  // ----------------------------------------
  typedef enum logic [1:0] {
    OP_DP_RD = 2'b00,
    OP_DP_WR = 2'b01,
    OP_AP_RD = 2'b10,
    OP_AP_WR = 2'b11
  } host_op_e;

  // AP register index
  typedef logic [1:0] ap_addr_t;

  // ----------------------------------------
  // CTRL/STAT field layout
  // ----------------------------------------
  typedef struct packed {
    logic [1:0]  rsvd_31_30;
    logic        cdbgpwrupack;   // Bit 29, live power acknowledge
    logic        cdbgpwrupreq;   // Bit 28, software power request
    logic [21:0] rsvd_27_6;
    logic        stickyerr;      // Bit 5, set by a blocked AP access
    logic [1:0]  rsvd_4_3;
    logic        clr_stickyerr;  // Bit 2, write one to clear, reads zero
    logic [1:0]  rsvd_1_0;
  } ctrl_stat_t;

  // Host data word
  // Decoded as CTRL/STAT fields for DP targets, passed raw for AP targets
  typedef union packed {
    logic [31:0] raw;
    ctrl_stat_t  fld;
  } ctrl_stat_u;

endpackage

// ==== src/dp_pwr_ctrl.sv ====
// Debug power controller splitting the software request into pend and commit stages
`timescale 1ns/100ps

module dp_pwr_ctrl (
  input  logic swclktck,
  input  logic dpreset_n,
  input  logic sw_pwrupreq_i,
  input  logic cdbgpwrupack_i,
  input  logic dp_req_i,
  input  logic ap_ack_i,
  output logic sw_pwrupack_o,
  output logic cdbgpwrupreq_o,
  output logic reset_handshake_o
);

  logic ack_meta_q;
  logic ack_sync_q;
  logic pend_q;
  logic commit_q;
  logic pend_load;
  logic commit_load;

  // ----------------------------------------
  // Acknowledge synchronizer
  // ----------------------------------------
  // Pin comes from the system power controller, so two flops
  always_ff @(posedge swclktck or negedge dpreset_n)
  begin
    if (!dpreset_n)
    begin
      ack_meta_q <= 1'b0;
      ack_sync_q <= 1'b0;
    end
    else
    begin
      ack_meta_q <= cdbgpwrupack_i;
      ack_sync_q <= ack_meta_q;
    end
  end

  // ----------------------------------------
  // Pend and commit stages
  // ----------------------------------------
  // Pend follows software only after the pin has answered its last value
  assign pend_load   = (pend_q == ack_sync_q);
  // Commit only while the AP link rests with both lines low
  assign commit_load = !dp_req_i && !ap_ack_i;

  always_ff @(posedge swclktck or negedge dpreset_n)
  begin
    if (!dpreset_n)
    begin
      pend_q   <= 1'b0;
      commit_q <= 1'b0;
    end
    else
    begin
      if (pend_load)
        pend_q <= sw_pwrupreq_i;
      if (commit_load)
        commit_q <= pend_q;
    end
  end

  // Software sees the ack only once the request has reached the pin
  assign sw_pwrupack_o  = ack_sync_q && (!sw_pwrupreq_i || (pend_q && commit_q));
  assign cdbgpwrupreq_o = commit_q;

  // Link resting high blocks a power down, so ask for a dummy read
  assign reset_handshake_o = dp_req_i && ap_ack_i && !pend_q;

endmodule
